// File: include/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// ==============================
// address map
// ==============================
// boot code lives outside the cached region
`define RESET_PC      32'h3000_0000
`define SDRAM_BASE    32'ha000_0000
// first address past the sdram window
`define SDRAM_LIMIT   32'ha200_0000

// ==============================
// cache geometry
// ==============================
`define CACHE_LINES   16
`define LINE_WORDS    4
`define WORD_OFF_BITS 2
`define INDEX_BITS    4
`define TAG_BITS      24
`define OFF_LSB       2
`define INDEX_LSB     (`OFF_LSB + `WORD_OFF_BITS)
`define TAG_LSB       (`INDEX_LSB + `INDEX_BITS)

// arlen counts beats minus one
`define BURST_LEN     (`LINE_WORDS - 1)
`define BURST_FIXED   2'b00
`define BURST_INCR    2'b01
`define JAL_OPCODE    7'b1101111

`endif

// File: source/fetch_types_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

package fetch_types_pkg;

	typedef logic [31:0] addr_t; // byte address
	typedef logic [31:0] inst_t; // one rv32 instruction word

	// fields of an address as the cache splits it
	typedef logic [`INDEX_BITS-1:0]    line_idx_t;
	typedef logic [`TAG_BITS-1:0]      line_tag_t;
	typedef logic [`WORD_OFF_BITS-1:0] word_off_t;

	typedef enum logic [1:0] {
		IDLE,    // retire slot empty
		HOLD,    // retiring and waiting for retire_ready
		REDIRECT // holding a jal while redirect pulses
	} jump_state_t;

endpackage

`default_nettype wire

// File: source/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

	typedef logic [1:0] burst_t;     // arburst encoding
	typedef logic [3:0] burst_len_t; // arlen, beats minus one
	typedef logic [1:0] resp_t;      // rresp encoding

	typedef enum logic [2:0] {
		LOOKUP,   // start an access or take the cache answer
		BUS_WAIT, // address phase and the beat of an uncached read
		REFILL,   // burst beats streaming into the cache
		DELIVER,  // word fetched while the consumer slot is still full
		DRAIN     // redirected and letting the old access run out
	} fetch_state_t;

endpackage

`default_nettype wire

// File: source/inst_fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module inst_fetch_unit
	import fetch_types_pkg::*, mem_bus_pkg::*;
(
	input  wire             clock,
	input  wire             arst_n,

	output addr_t           araddr,
	output logic            arvalid,
	input  wire             arready,
	output burst_t          arburst,
	output burst_len_t      arlen,
	input  wire inst_t      rdata,
	input  wire resp_t      rresp,
	input  wire             rlast,
	input  wire             rvalid,
	output logic            rready,

	output logic            cache_req,
	output addr_t           cache_addr,
	input  wire             cache_rvalid,
	input  wire             cache_hit,
	input  wire inst_t      cache_rdata,
	output logic            cache_wvalid,
	output addr_t           cache_waddr,
	output inst_t           cache_wdata,
	input  wire             cache_bvalid,

	output inst_t           inst,
	output addr_t           inst_pc,
	output logic            inst_valid,
	input  wire             inst_ready,
	input  wire             redirect,
	input  wire addr_t      redirect_pc
);

	fetch_state_t state;
	addr_t        pc;          // address of the access being worked on
	inst_t        fetch_data;  // word parked while the consumer slot is full
	word_off_t    beat_off;    // offset of the next refill beat
	word_off_t    ack_cnt;     // refill writes acknowledged so far
	logic         lookup_busy; // cache answer is due this cycle
	logic         bus_open;    // read issued and last beat not seen yet
	logic         refill_open; // refill writes not all acknowledged

	logic         in_sdram;
	word_off_t    pc_off;
	logic         beat;
	logic         incr_beat;
	logic         refill_done;
	logic         start_fixed;
	logic         start_incr;
	logic         result_valid;
	inst_t        result_word;
	logic         slot_free;
	logic         load_slot;

	// ==============================
	// request side
	// ==============================
	assign rready     = 1'b1; // rresp is taken as is and never checked
	assign in_sdram   = (pc >= `SDRAM_BASE) && (pc < `SDRAM_LIMIT);
	assign pc_off     = pc[`OFF_LSB +: `WORD_OFF_BITS];
	assign cache_addr = pc;
	assign cache_req  = (state == LOOKUP) && !lookup_busy && in_sdram && !redirect;

	assign start_fixed = (state == LOOKUP) && !lookup_busy && !in_sdram && !redirect;
	assign start_incr  = (state == LOOKUP) && lookup_busy && cache_rvalid && !cache_hit &&
		!redirect; // a miss turns straight into a line burst

	assign beat        = rvalid && rready;
	assign incr_beat   = beat && (arburst == `BURST_INCR);
	assign refill_done = refill_open && cache_bvalid &&
		(ack_cnt == word_off_t'(`BURST_LEN));

	// ==============================
	// result hand-off
	// ==============================
	always_comb begin
		result_valid = 1'b0;
		result_word  = fetch_data;
		case (state)
			LOOKUP: begin
				result_valid = lookup_busy && cache_rvalid && cache_hit;
				result_word  = cache_rdata;
			end
			BUS_WAIT: begin
				result_valid = beat && (arburst == `BURST_FIXED);
				result_word  = rdata;
			end
			REFILL:  result_valid = refill_done; // word was captured during the burst
			DELIVER: result_valid = 1'b1;
			default: result_valid = 1'b0;
		endcase
	end

	assign slot_free = !inst_valid || inst_ready;
	assign load_slot = result_valid && slot_free && !redirect;

	// ==============================
	// control
	// ==============================
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state        <= LOOKUP;
			pc           <= `RESET_PC;
			lookup_busy  <= 1'b0;
			bus_open     <= 1'b0;
			refill_open  <= 1'b0;
			beat_off     <= '0;
			ack_cnt      <= '0;
			arvalid      <= 1'b0;
			cache_wvalid <= 1'b0;
			inst_valid   <= 1'b0;
		end else begin
			if (arvalid && arready)
				arvalid <= 1'b0;
			if (cache_req)
				lookup_busy <= 1'b1;
			else if (cache_rvalid)
				lookup_busy <= 1'b0;
			if (beat && rlast)
				bus_open <= 1'b0;
			if (refill_done)
				refill_open <= 1'b0;
			if (incr_beat)
				beat_off <= beat_off + 1'b1;
			if (cache_bvalid)
				ack_cnt <= ack_cnt + 1'b1;
			cache_wvalid <= incr_beat; // each refill beat becomes one write
			if (inst_valid && inst_ready)
				inst_valid <= 1'b0;

			if (redirect) begin
				pc         <= redirect_pc;
				inst_valid <= 1'b0; // the held word is on the wrong path
				state      <= (lookup_busy || bus_open || refill_open) ? DRAIN : LOOKUP;
			end else begin
				case (state)
					LOOKUP: begin
						if (start_fixed || start_incr) begin
							arvalid  <= 1'b1;
							bus_open <= 1'b1;
							state    <= BUS_WAIT;
						end
						if (start_incr) begin
							refill_open <= 1'b1;
							beat_off    <= '0;
							ack_cnt     <= '0;
						end
					end
					BUS_WAIT: begin
						if (arvalid && arready && (arburst == `BURST_INCR))
							state <= REFILL;
					end
					DRAIN: begin
						if (!lookup_busy && !bus_open && !refill_open)
							state <= LOOKUP; // old access fully retired from the bus
					end
					default: ;
				endcase
				if (load_slot) begin
					inst_valid <= 1'b1;
					pc         <= pc + 32'd4;
					state      <= LOOKUP;
				end else if (result_valid) begin
					state <= DELIVER;
				end
			end
		end
	end

	// ==============================
	// payload
	// ==============================
	always_ff @(posedge clock) begin
		if (start_fixed) begin
			araddr  <= pc;
			arburst <= `BURST_FIXED;
			arlen   <= '0;
		end
		if (start_incr) begin
			araddr  <= pc & ~addr_t'(`LINE_WORDS * 4 - 1); // line aligned
			arburst <= `BURST_INCR;
			arlen   <= burst_len_t'(`BURST_LEN);
		end
		if (incr_beat) begin
			cache_waddr <= araddr | addr_t'({beat_off, 2'b00});
			cache_wdata <= rdata;
		end
		if (incr_beat && (beat_off == pc_off))
			fetch_data <= rdata; // the word the pc asked for
		else if (result_valid)
			fetch_data <= result_word;
		if (load_slot) begin
			inst    <= result_word;
			inst_pc <= pc;
		end
	end

endmodule

`default_nettype wire

// File: source/inst_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module inst_cache
	import fetch_types_pkg::*;
(
	input  wire        clock,
	input  wire        arst_n,

	input  wire        cache_req,
	input  wire addr_t cache_addr,
	output logic       cache_rvalid,
	output logic       cache_hit,
	output inst_t      cache_rdata,

	input  wire        cache_wvalid,
	input  wire addr_t cache_waddr,
	input  wire inst_t cache_wdata,
	output logic       cache_bvalid
);

	// ==============================
	// storage
	// ==============================
	line_tag_t               tag_mem  [`CACHE_LINES];
	inst_t                   data_mem [`CACHE_LINES * `LINE_WORDS];
	logic [`CACHE_LINES-1:0] line_valid;

	line_idx_t rd_idx;
	line_tag_t rd_tag;
	word_off_t rd_off;
	line_idx_t wr_idx;
	line_tag_t wr_tag;
	word_off_t wr_off;
	logic      tag_match;
	logic      wr_first;
	logic      wr_last;

	// ==============================
	// address fields
	// ==============================
	assign rd_idx = cache_addr[`INDEX_LSB +: `INDEX_BITS];
	assign rd_tag = cache_addr[`TAG_LSB +: `TAG_BITS];
	assign rd_off = cache_addr[`OFF_LSB +: `WORD_OFF_BITS];

	assign wr_idx = cache_waddr[`INDEX_LSB +: `INDEX_BITS];
	assign wr_tag = cache_waddr[`TAG_LSB +: `TAG_BITS];
	assign wr_off = cache_waddr[`OFF_LSB +: `WORD_OFF_BITS];

	assign tag_match = line_valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	assign wr_first  = cache_wvalid && (wr_off == '0);
	assign wr_last   = cache_wvalid && (wr_off == word_off_t'(`LINE_WORDS - 1));

	// ==============================
	// handshakes and valid bits
	// ==============================
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			cache_rvalid <= 1'b0;
			cache_hit    <= 1'b0;
			cache_bvalid <= 1'b0;
			line_valid   <= '0;
		end else begin
			cache_rvalid <= cache_req;              // answer exactly one cycle later
			cache_hit    <= cache_req && tag_match;
			cache_bvalid <= cache_wvalid;           // one ack per refill word
			// a line is unusable while its words are being replaced
			if (wr_first)
				line_valid[wr_idx] <= 1'b0;
			else if (wr_last)
				line_valid[wr_idx] <= 1'b1;
		end
	end

	// ==============================
	// data and tag arrays
	// ==============================
	always_ff @(posedge clock) begin
		if (cache_req)
			cache_rdata <= data_mem[{rd_idx, rd_off}];
		if (cache_wvalid)
			data_mem[{wr_idx, wr_off}] <= cache_wdata;
		if (wr_last)
			tag_mem[wr_idx] <= wr_tag; // tag lands together with the valid bit
	end

endmodule

`default_nettype wire

// File: source/jump_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module jump_stage
	import fetch_types_pkg::*;
(
	input  wire        clock,
	input  wire        arst_n,

	input  wire inst_t inst,
	input  wire addr_t inst_pc,
	input  wire        inst_valid,
	output logic       inst_ready,

	output logic       redirect,
	output addr_t      redirect_pc,

	output logic       retire_valid,
	output addr_t      retire_pc,
	output inst_t      retire_inst,
	input  wire        retire_ready
);

	jump_state_t state;
	logic        accept;
	logic        is_jal;
	addr_t       jal_imm;

	assign is_jal  = (inst[6:0] == `JAL_OPCODE);
	assign jal_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0}; // j-type

	// nothing is taken while a redirect is going out
	assign inst_ready   = (state == IDLE) || ((state == HOLD) && retire_ready);
	assign accept       = inst_valid && inst_ready;
	assign redirect     = (state == REDIRECT);
	assign retire_valid = (state != IDLE);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else if (accept) begin
			state <= is_jal ? REDIRECT : HOLD;
		end else begin
			case (state)
				HOLD: begin
					if (retire_ready)
						state <= IDLE;
				end
				REDIRECT: state <= retire_ready ? IDLE : HOLD; // redirect lasts one cycle
				default:  state <= state;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			retire_pc   <= inst_pc;
			retire_inst <= inst;
			redirect_pc <= inst_pc + jal_imm;
		end
	end

endmodule

`default_nettype wire

// File: source/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top
	import fetch_types_pkg::*, mem_bus_pkg::*;
(
	input  wire             clock,
	input  wire             arst_n,

	output wire addr_t      araddr,
	output wire             arvalid,
	input  wire             arready,
	output wire burst_t     arburst,
	output wire burst_len_t arlen,
	input  wire inst_t      rdata,
	input  wire resp_t      rresp,
	input  wire             rlast,
	input  wire             rvalid,

	output wire             retire_valid,
	output wire addr_t      retire_pc,
	output wire inst_t      retire_inst,
	input  wire             retire_ready
);

	wire        rready; // always high inside the fetch unit

	// ==============================
	// fetch unit to cache
	// ==============================
	wire        cache_req;
	wire addr_t cache_addr;
	wire        cache_rvalid;
	wire        cache_hit;
	wire inst_t cache_rdata;
	wire        cache_wvalid;
	wire addr_t cache_waddr;
	wire inst_t cache_wdata;
	wire        cache_bvalid;

	// ==============================
	// fetch unit to jump stage
	// ==============================
	wire inst_t inst;
	wire addr_t inst_pc;
	wire        inst_valid;
	wire        inst_ready;
	wire        redirect;
	wire addr_t redirect_pc;

	inst_fetch_unit fetch_unit_i (.*);

	inst_cache cache_i (.*);

	jump_stage jump_i (.*);

endmodule

`default_nettype wire

// File: verif/fetch_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_chk
	import fetch_types_pkg::*, mem_bus_pkg::*;
(
	input wire         clock,
	input wire         arst_n,
	input wire addr_t  araddr,
	input wire         arvalid,
	input wire         arready,
	input wire burst_t arburst,
	input wire         cache_wvalid,
	input wire         cache_rvalid,
	input wire         inst_valid,
	input wire         redirect,
	input wire         retire_valid
);

	// ==============================
	// read address channel
	// ==============================
	ap_ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid dropped or araddr moved before arready");

	// a burst always covers exactly one cache line
	ap_incr_line: assert property (@(posedge clock) disable iff (!arst_n)
		arvalid && (arburst == `BURST_INCR) |->
			(araddr >= `SDRAM_BASE) && (araddr < `SDRAM_LIMIT) &&
			((araddr & (`LINE_WORDS * 4 - 1)) == 0))
		else $error("incr burst outside the sdram window or not line aligned");

	ap_redirect_pulse: assert property (@(posedge clock) disable iff (!arst_n)
		redirect |=> !redirect)
		else $error("redirect held for more than one cycle");

	ap_reset_quiet: assert property (@(posedge clock)
		!arst_n |-> !arvalid && !cache_wvalid && !cache_rvalid && !inst_valid &&
			!redirect && !retire_valid)
		else $error("a valid or redirect output is high during reset");

endmodule

bind fetch_top fetch_chk chk_i (
	.clock(clock), .arst_n(arst_n),
	.araddr(araddr), .arvalid(arvalid), .arready(arready), .arburst(arburst),
	.cache_wvalid(cache_wvalid), .cache_rvalid(cache_rvalid),
	.inst_valid(inst_valid), .redirect(redirect), .retire_valid(retire_valid)
);

`default_nettype wire

// File: verif/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_tb
	import fetch_types_pkg::*, mem_bus_pkg::*;
();

	logic        clock;
	logic        arst_n;
	addr_t       araddr;
	logic        arvalid;
	logic        arready;
	burst_t      arburst;
	burst_len_t  arlen;
	inst_t       rdata;
	resp_t       rresp;
	logic        rlast;
	logic        rvalid;
	logic        retire_valid;
	addr_t       retire_pc;
	inst_t       retire_inst;
	logic        retire_ready;

	inst_t       mem [addr_t]; // sparse memory image
	addr_t       exp_pc [$];
	inst_t       exp_inst [$];
	addr_t       req_addr [$]; // accepted reads that still owe beats
	burst_len_t  req_len [$];
	logic [31:0] rng;
	logic        loaded;
	logic        ready_now;
	burst_t      want_burst;
	burst_len_t  want_len;
	int          exp_bursts;
	int          bursts;
	int          retired;
	int          beat_idx;
	int          ar_wait;
	int          errors;

	fetch_top fetch_top_i (.*);

	// ==============================
	// helpers
	// ==============================
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic inst_t read_word(addr_t a);
		if (mem.exists(a))
			return mem[a];
		return {a[24:0] ^ a[31:7], 7'h13}; // unloaded words decode as op-imm, never jal
	endfunction

	task automatic load_cases();
		int          fd;
		int          n;
		string       line;
		byte         kind;
		logic [31:0] a;
		logic [31:0] d;
		fd = $fopen("verif/fetch_cases.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0)
					n = $sscanf(line, "%c %h %h", kind, a, d);
				if (n == 3 && kind == "M") begin
					mem[a] = d;
				end else if (n == 3 && kind == "E") begin
					exp_pc.push_back(a);
					exp_inst.push_back(d);
				end else if (n >= 2 && kind == "B") begin
					exp_bursts = int'(a);
				end
			end
			$fclose(fd);
		end
		loaded = (fd != 0);
	endtask

	// ==============================
	// memory and retire side
	// ==============================
	always @(negedge clock) begin
		if (arst_n) begin
			// retire port stalls about one cycle in four
			ready_now = (next_rand() % 4) != 0;
			if (retire_valid && ready_now && retired < exp_pc.size()) begin
				if (retire_pc !== exp_pc[retired]) begin
					$display("[ERROR] %0t retire_pc expected %h got %h",
						$time, exp_pc[retired], retire_pc);
					errors++;
				end
				if (retire_inst !== exp_inst[retired]) begin
					$display("[ERROR] %0t retire_inst expected %h got %h",
						$time, exp_inst[retired], retire_inst);
					errors++;
				end
				retired++;
			end
			retire_ready = ready_now;

			rvalid = 1'b0;
			rlast  = 1'b0;
			if (req_addr.size() > 0 && (next_rand() % 4) != 0) begin
				rvalid = 1'b1;
				rdata  = read_word(req_addr[0] + 32'(4 * beat_idx)); // fixed reads stay at beat 0
				rlast  = (beat_idx == int'(req_len[0]));
				beat_idx++;
				if (rlast) begin
					beat_idx = 0;
					void'(req_addr.pop_front());
					void'(req_len.pop_front());
				end
			end

			arready = 1'b0;
			if (arvalid && ar_wait > 0) begin
				ar_wait--;
			end else if (arvalid) begin
				arready = 1'b1;
				if ((araddr >= `SDRAM_BASE) && (araddr < `SDRAM_LIMIT)) begin
					want_burst = `BURST_INCR;
					want_len   = burst_len_t'(`LINE_WORDS - 1);
				end else begin
					want_burst = `BURST_FIXED;
					want_len   = '0;
				end
				if (arburst !== want_burst) begin
					$display("[ERROR] %0t arburst expected %h got %h", $time, want_burst, arburst);
					errors++;
				end
				if (arlen !== want_len) begin
					$display("[ERROR] %0t arlen expected %h got %h", $time, want_len, arlen);
					errors++;
				end
				if (arburst == `BURST_INCR)
					bursts++;
				req_addr.push_back(araddr);
				req_len.push_back(arlen);
				ar_wait = int'(next_rand() % 4);
			end
		end
	end

	// ==============================
	// clock, reset and verdict
	// ==============================
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		rng          = 32'd89;
		errors       = 0;
		bursts       = 0;
		retired      = 0;
		beat_idx     = 0;
		ar_wait      = 0;
		exp_bursts   = 0;
		arst_n       = 1'b0;
		arready      = 1'b0;
		rdata        = '0;
		rresp        = '0;
		rlast        = 1'b0;
		rvalid       = 1'b0;
		retire_ready = 1'b0;
		load_cases();
		if (!loaded) begin
			$display("could not open verif/fetch_cases.txt");
			$display("** FAIL **");
			$finish;
		end else begin
			repeat (16) @(negedge clock);
			arst_n <= 1'b1; // memory side starts on the following falling edge
			wait (retired == exp_pc.size());
			if (bursts != exp_bursts) begin
				$display("[ERROR] %0t incr burst count expected %0d got %0d",
					$time, exp_bursts, bursts);
				errors++;
			end
			$display("errors %0d, retired %0d of %0d, incr bursts %0d",
				errors, retired, exp_pc.size(), bursts);
			if (errors == 0) begin
				$display("** PASS **");
			end else begin
				$display("** FAIL **");
			end
			$finish;
		end
	end

	// 400 cycles for each expected retire
	initial begin
		wait (loaded === 1'b1);
		repeat (400 * exp_pc.size()) @(posedge clock);
		$display("timeout with %0d of %0d instructions retired", retired, exp_pc.size());
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
source/fetch_types_pkg.sv
source/mem_bus_pkg.sv
source/inst_fetch_unit.sv
source/inst_cache.sv
source/jump_stage.sv
source/fetch_top.sv
verif/fetch_chk.sv
verif/fetch_tb.sv

// File: verif/fetch_cases.txt
# M addr word = memory image, E pc inst = expected retire order, B n = expected incr bursts
# boot code only, a jal from the boot region cannot reach the sdram window
M 30000000 00000013
M 30000004 00100093
M 30000008 0100006f
M 3000000c 00200113
M 30000018 00300193
M 3000001c fe5ff06f
M 30000020 00400213
E 30000000 00000013
E 30000004 00100093
E 30000008 0100006f
E 30000018 00300193
E 3000001c fe5ff06f
E 30000000 00000013
E 30000004 00100093
E 30000008 0100006f
E 30000018 00300193
E 3000001c fe5ff06f
E 30000000 00000013
E 30000004 00100093
E 30000008 0100006f
E 30000018 00300193
E 3000001c fe5ff06f
B 0
